// File: hw/fb_cfg.svh
//////////////////////////////
// timing is for a 480x272 RGB LCD panel, porches in pixel clocks
// the framebuffer is 1 bit per pixel and sits at the top left corner
//////////////////////////////

`ifndef FB_CFG_SVH
`define FB_CFG_SVH

// horizontal timing in pixels
`define FB_H_ACTIVE 480
`define FB_H_FP     8   // front porch
`define FB_H_SYNC   4
`define FB_H_BP     39  // back porch

// vertical timing in lines
`define FB_V_ACTIVE 272
`define FB_V_FP     4
`define FB_V_SYNC   4
`define FB_V_BP     12

// framebuffer size
`define FB_WIDTH    160
`define FB_HEIGHT   120
`define FB_PIXELS   (`FB_WIDTH * `FB_HEIGHT)  // 19200
`define FB_ADDRW    15  // wide enough for FB_PIXELS

`define FB_CORDW    16  // signed screen coordinate width

// address register plus bram output register
`define FB_LAT      2

`endif

// File: hw/fb_pkg.sv
//////////////////////////////
// coordinate and address types shared by the display blocks
//////////////////////////////

`default_nettype none

`include "fb_cfg.svh"

package fb_pkg;

	// screen position, negative during blanking
	typedef logic signed [`FB_CORDW-1:0] coord_t;

	// pixel index into the framebuffer, row major
	typedef logic [`FB_ADDRW-1:0] fb_addr_t;

endpackage

`default_nettype wire

// File: hw/display_timing.sv
//////////////////////////////
// blanking sits at negative coordinates and the active area starts at 0,0
// syncs are active low and decoded straight from the counters
//////////////////////////////

`default_nettype none

`include "fb_cfg.svh"

module display_timing (
	input  wire logic clk_pix,
	input  wire logic reset,
	output fb_pkg::coord_t sx,  // horizontal position
	output fb_pkg::coord_t sy,  // vertical position
	output logic hsync,
	output logic vsync,
	output logic de,     // data enable in active area
	output logic frame   // one cycle at start of frame
	);

	// line starts in the front porch
	localparam fb_pkg::coord_t H_STA =
		fb_pkg::coord_t'(-(`FB_H_FP + `FB_H_SYNC + `FB_H_BP));
	localparam fb_pkg::coord_t HS_STA = fb_pkg::coord_t'(H_STA + `FB_H_FP);
	localparam fb_pkg::coord_t HS_END = fb_pkg::coord_t'(HS_STA + `FB_H_SYNC);
	localparam fb_pkg::coord_t HA_END = fb_pkg::coord_t'(`FB_H_ACTIVE - 1);  // last pixel

	// vertical positions use the same layout in lines
	localparam fb_pkg::coord_t V_STA =
		fb_pkg::coord_t'(-(`FB_V_FP + `FB_V_SYNC + `FB_V_BP));
	localparam fb_pkg::coord_t VS_STA = fb_pkg::coord_t'(V_STA + `FB_V_FP);
	localparam fb_pkg::coord_t VS_END = fb_pkg::coord_t'(VS_STA + `FB_V_SYNC);
	localparam fb_pkg::coord_t VA_END = fb_pkg::coord_t'(`FB_V_ACTIVE - 1);

	localparam fb_pkg::coord_t STEP = fb_pkg::coord_t'(1);

	// position counters
	always_ff @(posedge clk_pix) begin
		if (reset) begin
			sx <= H_STA;  // first blanking position
			sy <= V_STA;
		end else if (sx == HA_END) begin  // end of line
			sx <= H_STA;
			if (sy == VA_END) begin
				sy <= V_STA;  // wrap to next frame
			end else begin
				sy <= sy + STEP;
			end
		end else begin
			sx <= sx + STEP;
		end
	end

	// decode syncs and enables from the position
	always_comb begin
		hsync = !(sx >= HS_STA && sx < HS_END);  // active low
		vsync = !(sy >= VS_STA && sy < VS_END);
		de    = (sx >= 0 && sy >= 0);  // counters never pass the active end
		frame = (sx == H_STA && sy == V_STA);
	end

	// data enable must stay inside the visible area on both axes
	a_de_active: assert property (@(posedge clk_pix) disable iff (reset)
		de |-> (sx >= 0 && sx <= HA_END && sy >= 0 && sy <= VA_END))
		else $error("de outside active area at sx=%0d sy=%0d", sx, sy);

endmodule

`default_nettype wire

// File: hw/fb_bram_sdp.sv
//////////////////////////////
// one bit wide with write and read on the same clock and a registered read
// read during write of the same address returns the old value
//////////////////////////////

`default_nettype none

`include "fb_cfg.svh"

module fb_bram_sdp (
	input  wire logic clk_pix,
	input  wire logic we,                  // write strobe
	input  wire fb_pkg::fb_addr_t addr_write,
	input  wire logic data_in,
	input  wire fb_pkg::fb_addr_t addr_read,
	output logic data_out                  // valid one cycle after addr_read
	);

	logic mem [`FB_PIXELS];

	// blank screen at power up and as the fpga init value
	initial begin
		for (int i = 0; i < `FB_PIXELS; i++) begin
			mem[i] = 1'b0;
		end
	end

	always_ff @(posedge clk_pix) begin
		if (we) begin
			mem[addr_write] <= data_in;
		end
	end

	// scanout parks one past the end between frames so that reads as black
	always_ff @(posedge clk_pix) begin
		data_out <= (addr_read < `FB_PIXELS) ? mem[addr_read] : 1'b0;
	end

	// the writer range check must keep every write inside the array
	a_write_range: assert property (@(posedge clk_pix)
		we |-> addr_write < `FB_PIXELS)
		else $error("framebuffer write out of range, addr=%0d", addr_write);

endmodule

`default_nettype wire

// File: hw/fb_apb_writer.sv
//////////////////////////////
// write only, no wait states; paddr word index is the pixel index
// pwdata bit 0 is the pixel, reads and bad writes answer with pslverr
//////////////////////////////

`default_nettype none

`include "fb_cfg.svh"

module fb_apb_writer (
	input  wire logic clk_pix,
	input  wire logic reset,
	input  wire logic psel,
	input  wire logic penable,
	input  wire logic pwrite,
	input  wire logic [31:0] paddr,
	input  wire logic [31:0] pwdata,
	output logic pready,
	output logic [31:0] prdata,
	output logic pslverr,
	output logic we,                    // framebuffer write strobe
	output fb_pkg::fb_addr_t addr_write,
	output logic data_in
	);

	logic setup;     // first cycle of a transfer
	logic aligned;   // byte offset zero
	logic in_range;  // pixel index inside the buffer
	logic bad;       // transfer to refuse

	always_comb begin
		setup    = psel && !penable;
		aligned  = (paddr[1:0] == 2'b00);
		in_range = (paddr[31:2] < `FB_PIXELS);
		bad      = !pwrite || !aligned || !in_range;
	end

	// response lands in the access phase, built from setup values
	always_ff @(posedge clk_pix) begin
		if (reset) begin
			pready  <= 1'b0;
			pslverr <= 1'b0;
			we      <= 1'b0;
		end else begin
			pready  <= setup;         // every access phase is one cycle
			pslverr <= setup && bad;
			we      <= setup && !bad;  // write lands at end of access phase
		end
	end

	// address and data held for the access phase
	always_ff @(posedge clk_pix) begin
		if (setup) begin
			addr_write <= paddr[2 +: `FB_ADDRW];  // word index
			data_in    <= pwdata[0];
		end
	end

	assign prdata = '0;  // nothing to read back

	// access phase only ever follows a setup phase
	a_apb_setup: assert property (@(posedge clk_pix) disable iff (reset)
		$rose(penable) |-> $past(psel))
		else $error("penable rose without a setup phase");

endmodule

`default_nettype wire

// File: hw/fb_scanout.sv
//////////////////////////////
// reads FB_LAT pixels ahead so ram data meets its screen position
// outputs are registered one clock behind the timing signals
//////////////////////////////

`default_nettype none

`include "fb_cfg.svh"

module fb_scanout (
	input  wire logic clk_pix,
	input  wire logic reset,
	input  wire fb_pkg::coord_t sx,
	input  wire fb_pkg::coord_t sy,
	input  wire logic hsync,
	input  wire logic vsync,
	input  wire logic de,
	input  wire logic frame,
	output fb_pkg::fb_addr_t addr_read,
	input  wire logic pixel,          // ram data for addr_read of last cycle
	output logic vga_hsync,
	output logic vga_vsync,
	output logic vga_de,
	output logic [4:0] vga_r,
	output logic [5:0] vga_g,
	output logic [4:0] vga_b
	);

	// framebuffer window and the read window ahead of it
	localparam fb_pkg::coord_t FB_W     = fb_pkg::coord_t'(`FB_WIDTH);
	localparam fb_pkg::coord_t FB_H     = fb_pkg::coord_t'(`FB_HEIGHT);
	localparam fb_pkg::coord_t RD_X_STA = fb_pkg::coord_t'(-`FB_LAT);
	localparam fb_pkg::coord_t RD_X_END = fb_pkg::coord_t'(`FB_WIDTH - `FB_LAT);

	localparam logic [4:0] WHITE_R = 5'h1e;  // full scale 4 bit white shifted up
	localparam logic [5:0] WHITE_G = 6'h3c;
	localparam logic [4:0] WHITE_B = 5'h1e;

	logic read_fb;     // address steps this cycle
	logic paint_area;  // sx, sy inside the framebuffer
	logic paint_on;    // white pixel

	// read address is one of the FB_LAT stages
	always_ff @(posedge clk_pix) begin
		if (reset) begin
			read_fb   <= 1'b0;
			addr_read <= '0;
		end else begin
			read_fb <= (sy >= 0 && sy < FB_H && sx >= RD_X_STA && sx < RD_X_END);
			if (frame) begin
				addr_read <= '0;  // back to top left
			end else if (read_fb) begin
				addr_read <= addr_read + fb_pkg::fb_addr_t'(1);
			end
		end
	end

	always_comb begin
		paint_area = (sy >= 0 && sy < FB_H && sx >= 0 && sx < FB_W);
		paint_on   = paint_area && pixel;  // black outside window
	end

	// panel outputs
	always_ff @(posedge clk_pix) begin
		if (reset) begin
			vga_hsync <= 1'b1;  // inactive
			vga_vsync <= 1'b1;
			vga_de    <= 1'b0;
			vga_r     <= '0;
			vga_g     <= '0;
			vga_b     <= '0;
		end else begin
			vga_hsync <= hsync;
			vga_vsync <= vsync;
			vga_de    <= de;
			vga_r     <= (de && paint_on) ? WHITE_R : 5'h00;  // black in blanking
			vga_g     <= (de && paint_on) ? WHITE_G : 6'h00;
			vga_b     <= (de && paint_on) ? WHITE_B : 5'h00;
		end
	end

	// a whole frame must read every pixel exactly once
	a_frame_reads: assert property (@(posedge clk_pix) disable iff (reset)
		frame ##1 frame[->1] |-> addr_read == `FB_PIXELS)
		else $error("frame ended with read address %0d", addr_read);

endmodule

`default_nettype wire

// File: hw/mono_display_top.sv
//////////////////////////////
// reset must already be synchronous to clk_pix
// framebuffer is filled over apb and starts blank
//////////////////////////////

`default_nettype none

module mono_display_top (
	input  wire logic clk_pix,
	input  wire logic reset,
	input  wire logic psel,
	input  wire logic penable,
	input  wire logic pwrite,
	input  wire logic [31:0] paddr,
	input  wire logic [31:0] pwdata,
	output logic pready,
	output logic [31:0] prdata,
	output logic pslverr,
	output logic vga_hsync,
	output logic vga_vsync,
	output logic vga_de,
	output logic [4:0] vga_r,
	output logic [5:0] vga_g,
	output logic [4:0] vga_b
	);

	fb_pkg::coord_t sx, sy;            // screen position
	logic hsync, vsync, de, frame;
	logic we;                          // apb side of the ram
	fb_pkg::fb_addr_t addr_write;
	logic data_in;
	fb_pkg::fb_addr_t addr_read;       // scanout side
	logic pixel;

	display_timing u_display_timing (
		.clk_pix, .reset, .sx, .sy, .hsync, .vsync, .de, .frame
	);

	fb_apb_writer u_fb_apb_writer (
		.clk_pix, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
		.pready, .prdata, .pslverr, .we, .addr_write, .data_in
	);

	fb_bram_sdp u_fb_bram_sdp (
		.clk_pix, .we, .addr_write, .data_in, .addr_read,
		.data_out(pixel)
	);

	fb_scanout u_fb_scanout (
		.clk_pix, .reset, .sx, .sy, .hsync, .vsync, .de, .frame,
		.addr_read, .pixel,
		.vga_hsync, .vga_vsync, .vga_de, .vga_r, .vga_g, .vga_b
	);

endmodule

`default_nettype wire

// File: testbench/tb_mono_display.sv
//////////////////////////////
// all apb traffic is placed in vertical blanking so every checked frame is whole
// apb base is 0 and white is the 5-6-5 value that scanout drives
//////////////////////////////

`default_nettype none

`include "fb_cfg.svh"

module tb_mono_display;

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [15:0] WHITE = {5'h1e, 6'h3c, 5'h1e};  // r, g, b
	localparam logic [31:0] APB_BASE = 32'h0000_0000;
	localparam int LINE_CYCLES = `FB_H_ACTIVE + `FB_H_FP + `FB_H_SYNC + `FB_H_BP;
	localparam int FRAME_CYCLES =
		LINE_CYCLES * (`FB_V_ACTIVE + `FB_V_FP + `FB_V_SYNC + `FB_V_BP);
	// lead in to first vsync plus three checked frames and some slack
	localparam int LIMIT = 3 * FRAME_CYCLES + 8 * LINE_CYCLES + 1000;

	logic clk_pix, reset;
	logic psel, penable, pwrite;
	logic [31:0] paddr, pwdata, prdata;
	logic pready, pslverr;
	logic vga_hsync, vga_vsync, vga_de;
	logic [4:0] vga_r, vga_b;
	logic [5:0] vga_g;
	logic [15:0] colour;

	logic [`FB_PIXELS-1:0] model = '0;  // expected framebuffer in row major order
	logic exp_err;     // refusal expected for the current transfer
	logic exp_white;   // model bit at the current panel position
	logic seen_vsync;  // a full frame has started
	int col, row;      // panel position from vga_de and vga_vsync
	int cycles = 0;
	int errors = 0;
	int passed = 0;
	int failed = 0;
	logic [31:0] rng = 32'hfe76;
	int set_q[$];  // pixels written as 1

	mono_display_top u_mono_display_top (
		.clk_pix, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
		.pready, .prdata, .pslverr,
		.vga_hsync, .vga_vsync, .vga_de, .vga_r, .vga_g, .vga_b
	);

	assign colour = {vga_r, vga_g, vga_b};

	initial begin
		clk_pix = 1'b0;
		forever #10 clk_pix = ~clk_pix;  // 50 MHz
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] pixel_addr(input int idx);
		return APB_BASE + (32'(idx) << 2);  // one word per pixel
	endfunction

	function automatic void report_mismatch(input string msg);
		errors++;
		$display("mismatch at %0t: %s", $time, msg);
	endfunction

	task automatic close_test(input string name, input int errs_at);
		if (errors == errs_at) begin
			passed++;
			$display("test %s: ok", name);
		end else begin
			failed++;
			$display("test %s: %0d errors", name, errors - errs_at);
		end
	endtask

	// setup and access phase with the model following accepted writes
	task automatic apb_xfer(input logic write, input logic [31:0] addr,
			input logic [31:0] data);
		logic bad;
		bad = !write || addr[1:0] != 2'b00 || addr[31:2] >= `FB_PIXELS;
		@(negedge clk_pix);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		exp_err = bad;
		@(negedge clk_pix);
		penable = 1'b1;  // access phase
		@(negedge clk_pix);
		psel = 1'b0;
		penable = 1'b0;
		if (!bad) begin
			model[addr[31:2]] = data[0];
		end
	endtask

	task automatic write_pixel(input int idx, input logic val);
		apb_xfer(1'b1, pixel_addr(idx), {rng[31:1], val});  // upper bits are noise
		if (val) begin
			set_q.push_back(idx);
		end
	endtask

	always_comb begin
		if (col < `FB_WIDTH && row < `FB_HEIGHT) begin
			exp_white = model[row * `FB_WIDTH + col];
		end else begin
			exp_white = 1'b0;  // outside the window
		end
	end

	// panel position is cleared by the vsync pulse
	always @(posedge clk_pix) begin
		if (reset || !vga_vsync) begin
			col <= 0;
			row <= 0;
		end else if (vga_de) begin
			col <= col + 1;
		end else if (col != 0) begin
			col <= 0;  // line just ended
			row <= row + 1;
		end
	end

	always @(posedge clk_pix) begin
		if (reset) begin
			seen_vsync <= 1'b0;
		end else if (!vga_vsync) begin
			seen_vsync <= 1'b1;
		end
	end

	always @(posedge clk_pix) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: no result after %0d clock cycles", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	a_reset_state: assert property (@(posedge clk_pix)
		$fell(reset) |-> !vga_de && vga_hsync && vga_vsync && colour == 16'h0)
		else report_mismatch("panel outputs not idle after reset");
	a_colour: assert property (@(posedge clk_pix) disable iff (reset)
		colour == ((vga_de && exp_white) ? WHITE : 16'h0))
		else report_mismatch($sformatf("colour %h at col %0d row %0d",
			$sampled(colour), $sampled(col), $sampled(row)));
	a_line_len: assert property (@(posedge clk_pix) disable iff (reset)
		(!vga_de && col != 0) |-> col == `FB_H_ACTIVE)
		else report_mismatch($sformatf("line of %0d pixels", $sampled(col)));
	a_hsync: assert property (@(posedge clk_pix) disable iff (reset)
		$fell(vga_de) |-> ##(`FB_H_FP) $fell(vga_hsync))
		else report_mismatch("hsync pulse not one front porch after the line");
	a_frame_rows: assert property (@(posedge clk_pix) disable iff (reset)
		($fell(vga_vsync) && seen_vsync) |-> row == `FB_V_ACTIVE)
		else report_mismatch($sformatf("frame of %0d lines", $sampled(row)));
	a_apb_ready: assert property (@(posedge clk_pix) disable iff (reset)
		(psel && penable) |-> pready && prdata == 32'h0)
		else report_mismatch("access phase without pready or with prdata set");
	a_apb_err: assert property (@(posedge clk_pix) disable iff (reset)
		(psel && penable) |-> pslverr == exp_err)
		else report_mismatch($sformatf("pslverr %b, expected %b",
			$sampled(pslverr), $sampled(exp_err)));

	initial begin
		int errs_at;
		int idx;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		exp_err = 1'b0;
		repeat (3) @(negedge clk_pix);
		reset = 1'b0;

		@(negedge vga_vsync);  // first full frame with the ram still zero
		errs_at = errors;
		@(negedge vga_vsync);
		close_test("blank frame after reset", errs_at);

		errs_at = errors;
		write_pixel(0, 1'b1);  // four corners of the window
		write_pixel(`FB_WIDTH - 1, 1'b1);
		write_pixel(`FB_PIXELS - `FB_WIDTH, 1'b1);
		write_pixel(`FB_PIXELS - 1, 1'b1);
		repeat (60) begin
			rng = xorshift(rng);
			idx = rng % `FB_PIXELS;
			write_pixel(idx, rng[20]);
		end
		@(negedge vga_vsync);  // frame after the writes
		close_test("random writes and corners", errs_at);

		errs_at = errors;
		apb_xfer(1'b0, pixel_addr(7), 32'(!model[7]));  // read
		apb_xfer(1'b1, pixel_addr(8) | 32'h2, 32'(!model[8]));  // misaligned
		apb_xfer(1'b1, pixel_addr(`FB_PIXELS), 32'h1);  // one past the end
		apb_xfer(1'b1, pixel_addr(9) | 32'h8000_0000, 32'(!model[9]));
		foreach (set_q[i]) begin
			if (i % 2 == 0) begin
				write_pixel(set_q[i], 1'b0);  // overwrite earlier ones
			end
		end
		@(negedge vga_vsync);
		close_test("refused transfers then clears", errs_at);

		$display("tests: %0d ok, %0d with errors, %0d errors in total",
			passed, failed, errors);
		if (failed == 0 && errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/fb_pkg.sv
hw/display_timing.sv
hw/fb_bram_sdp.sv
hw/fb_apb_writer.sv
hw/fb_scanout.sv
hw/mono_display_top.sv
testbench/tb_mono_display.sv

// File: Bender.yml
package:
  name: mono_display

sources:
  - include_dirs:
      - hw
    files:
      - hw/fb_pkg.sv
      - hw/display_timing.sv
      - hw/fb_bram_sdp.sv
      - hw/fb_apb_writer.sv
      - hw/fb_scanout.sv
      - hw/mono_display_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tb_mono_display.sv
